// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sbc_bus
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= PASS: all tests

SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM) tests/bus_stim.mem
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
source/sbc_bus_pkg.sv
source/bus_fabric.sv
source/main_ram.sv
source/seven_seg.sv
source/board_io.sv
source/irq_ctrl.sv
source/sbc_bus_top.sv
tests/bus_checker.sv
tests/tb_sbc_bus.sv

// ==== source/board_io.sv ====
`default_nettype none

module board_io import sbc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  wb_req_t    req,
    output wb_rsp_t    rsp,
    input  logic [7:0] sw,
    output logic [7:0] led
);

    logic       access;
    logic       ack_q;
    logic [7:0] dat_q;
    logic [7:0] sw_sync;

    assign access = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            led   <= 8'h00;
        end else begin
            ack_q <= access;
            if (access && req.we)
                led <= req.dat;
        end
    end

    always_ff @(posedge clk) begin
        sw_sync <= sw; // switches are asynchronous
        if (access)
            dat_q <= sw_sync;
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = dat_q;

endmodule

`default_nettype wire

// ==== source/bus_fabric.sv ====
`default_nettype none

module bus_fabric import sbc_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output wb_req_t ram_req,
    output wb_req_t hex_req,
    output wb_req_t io_req,
    output wb_req_t irq_req,
    input  wb_rsp_t ram_rsp,
    input  wb_rsp_t hex_rsp,
    input  wb_rsp_t io_rsp,
    input  wb_rsp_t irq_rsp
);

    region_t region;
    logic    none_ack;

    always_comb begin
        if (wb_req.adr <= RAM_LAST)
            region = REGION_RAM;
        else if (wb_req.adr[15:2] == HEX_BASE[15:2])
            region = REGION_HEX;
        else if (wb_req.adr == IO_ADDR)
            region = REGION_IO;
        else if (wb_req.adr == IRQ_ADDR)
            region = REGION_IRQ;
        else
            region = REGION_NONE;
    end

    always_comb begin
        ram_req     = wb_req;
        hex_req     = wb_req;
        io_req      = wb_req;
        irq_req     = wb_req;
        ram_req.stb = wb_req.stb && (region == REGION_RAM);
        hex_req.stb = wb_req.stb && (region == REGION_HEX);
        io_req.stb  = wb_req.stb && (region == REGION_IO);
        irq_req.stb = wb_req.stb && (region == REGION_IRQ);
    end

    // unmapped space answers itself
    always_ff @(posedge clk) begin
        if (rst)
            none_ack <= 1'b0;
        else
            none_ack <= wb_req.cyc && wb_req.stb && (region == REGION_NONE) && !none_ack;
    end

    always_comb begin
        wb_rsp.ack = ram_rsp.ack | hex_rsp.ack | io_rsp.ack | irq_rsp.ack | none_ack;
        case (region)
            REGION_RAM: wb_rsp.dat = ram_rsp.dat;
            REGION_HEX: wb_rsp.dat = hex_rsp.dat;
            REGION_IO:  wb_rsp.dat = io_rsp.dat;
            REGION_IRQ: wb_rsp.dat = irq_rsp.dat;
            default:    wb_rsp.dat = 8'hff; // open bus
        endcase
    end

    a_one_ack: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ram_rsp.ack, hex_rsp.ack, io_rsp.ack, irq_rsp.ack, none_ack}));

    a_ack_after_stb: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

`default_nettype wire

// ==== source/irq_ctrl.sv ====
`default_nettype none

module irq_ctrl import sbc_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t req,
    output wb_rsp_t rsp,
    input  logic    button_n,
    input  logic    irq_ext,
    output logic    irq_n
);

    logic [1:0] pending;
    logic       access;
    logic       ack_q;
    logic [7:0] dat_q;

    assign access = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q   <= 1'b0;
            pending <= 2'b00;
        end else begin
            ack_q <= access;
            if (access && req.we) begin
                pending <= pending & req.dat[1:0]; // clear beats a new event
            end else begin
                if (!button_n)
                    pending[0] <= 1'b1;
                if (irq_ext)
                    pending[1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            dat_q <= {6'b000000, pending};
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = dat_q;
    assign irq_n   = ~|pending;

endmodule

`default_nettype wire

// ==== source/main_ram.sv ====
`default_nettype none

module main_ram import sbc_bus_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [7:0]               mem [2**RAM_ADDR_BITS];
    logic [RAM_ADDR_BITS-1:0] idx;
    logic                     access;
    logic                     ack_q;
    logic [7:0]               dat_q;

    assign idx    = req.adr[RAM_ADDR_BITS-1:0]; // aliases above depth
    assign access = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst)
            ack_q <= 1'b0;
        else
            ack_q <= access;
    end

    always_ff @(posedge clk) begin
        if (access && req.we)
            mem[idx] <= req.dat;
        if (access)
            dat_q <= mem[idx];
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = dat_q;

    // master keeps the cycle open until it sees the ack
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ack_q |-> req.cyc && req.stb);

endmodule

`default_nettype wire

// ==== source/sbc_bus_pkg.sv ====
`default_nettype none

package sbc_bus_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_HEX,
        REGION_IO,
        REGION_IRQ,
        REGION_NONE
    } region_t;

    // active-low segments, bit 0 is segment a
    typedef struct packed {
        logic [6:0] hex5;
        logic [6:0] hex4;
        logic [6:0] hex3;
        logic [6:0] hex2;
        logic [6:0] hex1;
        logic [6:0] hex0;
    } seg_disp_t;

    localparam logic [15:0] RAM_LAST = 16'h7fff;
    localparam logic [15:0] HEX_BASE = 16'h8000; // 4 bytes, offset 3 reserved
    localparam logic [15:0] IO_ADDR  = 16'h8004;
    localparam logic [15:0] IRQ_ADDR = 16'h8005;

    function automatic logic [6:0] seg_font(input logic [3:0] val);
        case (val)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== source/sbc_bus_top.sv ====
`default_nettype none

module sbc_bus_top import sbc_bus_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic       clk,
    input  logic       rst,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    input  logic [7:0] sw,
    output logic [7:0] led,
    input  logic       button_n,
    input  logic       irq_ext,
    output logic       irq_n,
    output seg_disp_t  disp
);

    wb_req_t ram_req;
    wb_req_t hex_req;
    wb_req_t io_req;
    wb_req_t irq_req;
    wb_rsp_t ram_rsp;
    wb_rsp_t hex_rsp;
    wb_rsp_t io_rsp;
    wb_rsp_t irq_rsp;

    bus_fabric u_bus_fabric (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .ram_req (ram_req),
        .hex_req (hex_req),
        .io_req  (io_req),
        .irq_req (irq_req),
        .ram_rsp (ram_rsp),
        .hex_rsp (hex_rsp),
        .io_rsp  (io_rsp),
        .irq_rsp (irq_rsp)
    );

    main_ram #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_main_ram (
        .clk (clk),
        .rst (rst),
        .req (ram_req),
        .rsp (ram_rsp)
    );

    seven_seg u_seven_seg (
        .clk  (clk),
        .rst  (rst),
        .req  (hex_req),
        .rsp  (hex_rsp),
        .disp (disp)
    );

    board_io u_board_io (
        .clk (clk),
        .rst (rst),
        .req (io_req),
        .rsp (io_rsp),
        .sw  (sw),
        .led (led)
    );

    irq_ctrl u_irq_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (irq_req),
        .rsp      (irq_rsp),
        .button_n (button_n),
        .irq_ext  (irq_ext),
        .irq_n    (irq_n)
    );

endmodule

`default_nettype wire

// ==== source/seven_seg.sv ====
`default_nettype none

module seven_seg import sbc_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  wb_req_t   req,
    output wb_rsp_t   rsp,
    output seg_disp_t disp
);

    logic [2:0][7:0] seg_reg;
    logic [1:0]      sel;
    logic            access;
    logic            ack_q;
    logic [7:0]      dat_q;

    assign sel    = req.adr[1:0];
    assign access = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q   <= 1'b0;
            seg_reg <= '0;
        end else begin
            ack_q <= access;
            if (access && req.we && sel != 2'd3)
                seg_reg[sel] <= req.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            dat_q <= (sel == 2'd3) ? 8'h00 : seg_reg[sel]; // offset 3 reserved
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = dat_q;

    // low nibble on even digit, high nibble on odd
    assign disp.hex0 = seg_font(seg_reg[0][3:0]);
    assign disp.hex1 = seg_font(seg_reg[0][7:4]);
    assign disp.hex2 = seg_font(seg_reg[1][3:0]);
    assign disp.hex3 = seg_font(seg_reg[1][7:4]);
    assign disp.hex4 = seg_font(seg_reg[2][3:0]);
    assign disp.hex5 = seg_font(seg_reg[2][7:4]);

endmodule

`default_nettype wire

// ==== tests/bus_checker.sv ====
`default_nettype none

module bus_checker import sbc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  wb_rsp_t    wb_rsp,
    input  logic       irq_n,
    input  logic [7:0] led,
    input  seg_disp_t  disp,
    input  logic [3:0] test_id,
    input  int         line_no,
    input  logic       check_dat,
    input  logic [7:0] exp_dat,
    input  logic       exp_irq_n,
    input  logic [7:0] exp_led,
    input  seg_disp_t  exp_disp,
    output int         err_count,
    output int         check_count
);

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'h1:    return "ram";
            4'h2:    return "seven_seg";
            4'h3:    return "board_io";
            4'h4:    return "irq";
            4'h5:    return "unmapped";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [47:0] expected,
                                 input logic [47:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("[ERROR] %s line %0d, %s: expected %0h, actual %0h",
                     test_name(test_id), line_no, what, expected, actual);
        end
    endtask

    // everything is sampled in the ack cycle
    always @(posedge clk) begin
        if (rst) begin
            err_count   = 0;
            check_count = 0;
        end else if (wb_rsp.ack) begin
            check_count++;
            if (check_dat)
                compare_value("read data", 48'(exp_dat), 48'(wb_rsp.dat));
            compare_value("irq_n", 48'(exp_irq_n), 48'(irq_n));
            compare_value("led", 48'(exp_led), 48'(led));
            compare_value("disp", 48'(exp_disp), 48'(disp));
        end
    end

endmodule

`default_nettype wire

// ==== tests/bus_stim.mem ====
// test op(1=wr) addr wdata sw button_n irq_ext exp_rdata exp_irq_n exp_led
// then expected segments hex5 hex4 hex3 hex2 hex1 hex0; test id 0 ends the list
1_1_0010_a5_00_1_0_00_1_00_40_40_40_40_40_40
1_1_0123_3c_00_1_0_00_1_00_40_40_40_40_40_40
1_1_7fff_81_00_1_0_00_1_00_40_40_40_40_40_40
1_0_0010_00_00_1_0_a5_1_00_40_40_40_40_40_40
1_0_0123_00_00_1_0_3c_1_00_40_40_40_40_40_40
1_0_0410_00_00_1_0_a5_1_00_40_40_40_40_40_40
1_0_03ff_00_00_1_0_81_1_00_40_40_40_40_40_40
2_1_8000_21_00_1_0_00_1_00_40_40_40_40_24_79
2_1_8001_43_00_1_0_00_1_00_40_40_19_30_24_79
2_1_8002_e5_00_1_0_00_1_00_06_12_19_30_24_79
2_0_8001_00_00_1_0_43_1_00_06_12_19_30_24_79
2_0_8003_00_00_1_0_00_1_00_06_12_19_30_24_79
3_1_8004_5a_00_1_0_00_1_5a_06_12_19_30_24_79
3_0_8004_00_c3_1_0_c3_1_5a_06_12_19_30_24_79
4_0_8005_00_00_0_0_01_0_5a_06_12_19_30_24_79
4_1_8005_fe_00_1_0_00_1_5a_06_12_19_30_24_79
4_0_8005_00_00_1_1_02_0_5a_06_12_19_30_24_79
4_1_8005_fd_00_1_0_00_1_5a_06_12_19_30_24_79
4_0_8005_00_00_1_0_00_1_5a_06_12_19_30_24_79
5_0_9000_00_00_1_0_ff_1_5a_06_12_19_30_24_79
5_1_9000_00_00_1_0_00_1_5a_06_12_19_30_24_79
5_0_0010_00_00_1_0_a5_1_5a_06_12_19_30_24_79
0_0_0000_00_00_0_0_00_0_00_00_00_00_00_00_00

// ==== tests/tb_sbc_bus.sv ====
`default_nettype none

module tb_sbc_bus import sbc_bus_pkg::*; ();

    localparam int  STIM_DEPTH  = 64;
    localparam int  ACK_TIMEOUT = 20;
    localparam time DRIVE_DLY   = 2;

    logic       clk = 1'b0;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic [7:0] sw;
    logic [7:0] led;
    logic       button_n;
    logic       irq_ext;
    logic       irq_n;
    seg_disp_t  disp;

    logic [115:0] stim [STIM_DEPTH];
    logic [3:0]   test_id;
    int           line_no;
    logic         check_dat;
    logic [7:0]   exp_dat;
    logic         exp_irq_n;
    logic [7:0]   exp_led;
    seg_disp_t    exp_disp;
    int           err_count;
    int           check_count;

    always #10 clk = ~clk;

    sbc_bus_top #(
        .RAM_ADDR_BITS (10)
    ) u_sbc_bus_top (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .sw       (sw),
        .led      (led),
        .button_n (button_n),
        .irq_ext  (irq_ext),
        .irq_n    (irq_n),
        .disp     (disp)
    );

    bus_checker u_bus_checker (
        .clk         (clk),
        .rst         (rst),
        .wb_rsp      (wb_rsp),
        .irq_n       (irq_n),
        .led         (led),
        .disp        (disp),
        .test_id     (test_id),
        .line_no     (line_no),
        .check_dat   (check_dat),
        .exp_dat     (exp_dat),
        .exp_irq_n   (exp_irq_n),
        .exp_led     (exp_led),
        .exp_disp    (exp_disp),
        .err_count   (err_count),
        .check_count (check_count)
    );

    // board inputs and expected values for one stim line
    task automatic load_line(input int idx);
        test_id       = stim[idx][115:112];
        line_no       = idx;
        check_dat     = !stim[idx][108]; // reads only
        sw            = stim[idx][83:76];
        button_n      = stim[idx][72];
        irq_ext       = stim[idx][68];
        exp_dat       = stim[idx][67:60];
        exp_irq_n     = stim[idx][56];
        exp_led       = stim[idx][55:48];
        exp_disp.hex5 = stim[idx][46:40];
        exp_disp.hex4 = stim[idx][38:32];
        exp_disp.hex3 = stim[idx][30:24];
        exp_disp.hex2 = stim[idx][22:16];
        exp_disp.hex1 = stim[idx][14:8];
        exp_disp.hex0 = stim[idx][6:0];
    endtask

    task automatic wb_access(input logic we, input logic [15:0] adr, input logic [7:0] dat,
                             output logic ok);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        waited     = 0;
        ok         = 1'b0;
        while (!ok && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            ok = wb_rsp.ack;
            waited++;
        end
        #DRIVE_DLY;
        wb_req = '0;
    endtask

    initial begin
        int   i;
        logic ok;
        rst       = 1'b1;
        wb_req    = '0;
        sw        = 8'h00;
        button_n  = 1'b1;
        irq_ext   = 1'b0;
        test_id   = 4'h0;
        line_no   = 0;
        check_dat = 1'b0;
        exp_dat   = 8'h00;
        exp_irq_n = 1'b1;
        exp_led   = 8'h00;
        exp_disp  = '0;
        $readmemh("tests/bus_stim.mem", stim);
        repeat (2) @(posedge clk);
        #DRIVE_DLY rst = 1'b0;
        i  = 0;
        ok = 1'b1;
        while (ok && i < STIM_DEPTH && stim[i][115:112] != 4'h0) begin // id 0 ends the list
            load_line(i);
            repeat (3) @(posedge clk); // sync and irq flags settle
            #DRIVE_DLY;
            wb_access(stim[i][108], stim[i][107:92], stim[i][91:84], ok);
            if (!ok)
                $display("no ack from DUT at stim line %0d", i);
            i++;
        end
        if (check_count == 0)
            $display("no stimulus lines were run");
        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, err_count, !ok);
        if (ok && err_count == 0 && check_count > 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
